//--- common/wb_cfg.svh
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// Datapath widths
`define WB_XLEN         32              // Data and address width
`define WB_CSR_AW       12              // CSR address width

// PC loaded on reset
`define WB_PC_RESET     32'h8000_0000

// LSU micro-op layout
// --------------------
`define WB_LSU_LOAD     0               // Load flag
`define WB_LSU_SZ_LO    1               // Size field is bits 2:1
`define WB_LSU_SIGNED   3               // Sign-extend load data
`define WB_LSU_STORE    4               // Store flag

// CSR micro-op layout
// --------------------
`define WB_CSR_RD       0               // Read old value into GPR
`define WB_CSR_WR       1               // Plain write
`define WB_CSR_SET      2               // Set bits
`define WB_CSR_CLR      3               // Clear bits

`endif

//--- common/wb_pkg.sv
`include "wb_cfg.svh"

package wb_pkg;

    // Plain vectors
    // --------------------
    typedef logic [`WB_XLEN-1:0]   word_t;      // Data or address word
    typedef logic [4:0]            reg_idx_t;   // GPR index
    typedef logic [4:0]            uop_t;       // Micro-op
    typedef logic [`WB_CSR_AW-1:0] csr_addr_t;  // CSR address
    typedef logic [1:0]            isize_t;     // Halfwords, 0 = none

    // Functional unit select
    typedef enum logic [2:0] {
        FU_ALU = 3'd0,
        FU_LSU = 3'd1,
        FU_CFU = 3'd2,
        FU_CSR = 3'd3
    } fu_e;

    // Control-flow ops, carried in the micro-op
    typedef enum logic [4:0] {
        CFU_TAKEN  = 5'd1,              // Conditional branch, taken
        CFU_JALI   = 5'd2,
        CFU_JALR   = 5'd3,
        CFU_EBREAK = 5'd4,
        CFU_ECALL  = 5'd5,
        CFU_MRET   = 5'd6,
        CFU_NOP    = 5'd7               // Branch not taken
    } cfu_op_e;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,
        LSU_HALF = 2'd1,
        LSU_WORD = 2'd2
    } lsu_size_e;

    // Machine trap causes
    typedef enum logic [5:0] {
        TRAP_IOPCODE  = 6'd2,
        TRAP_BREAKPT  = 6'd3,
        TRAP_LDACCESS = 6'd5,
        TRAP_STACCESS = 6'd7,
        TRAP_ECALLM   = 6'd11
    } trap_cause_e;

endpackage

//--- source/wb_pc_tracker.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_pc_tracker import wb_pkg::*; (
    input  logic   g_clk,
    input  logic   g_resetn,
    input  logic   s4_valid,
    input  logic   s4_busy,
    input  isize_t s4_size,
    input  logic   cf_req,
    input  logic   cf_ack,
    input  word_t  cf_target,
    output logic   pipe_progress,
    output word_t  s4_pc,
    output word_t  next_pc
);

    assign pipe_progress = s4_valid && !s4_busy;  // Instruction retires

    // Size counts halfwords, so step by 2 * size bytes
    assign next_pc = s4_pc + word_t'({s4_size, 1'b0});

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_pc <= `WB_PC_RESET;
        end else if (cf_req && cf_ack) begin
            s4_pc <= cf_target;                   // Redirect wins
        end else if (pipe_progress) begin
            s4_pc <= next_pc;
        end
    end

    // PC frozen while stalled, unless a redirect completes
    a_pc_hold : assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_valid && s4_busy && !(cf_req && cf_ack) |=> $stable(s4_pc))
        else $error("PC moved during a stall");

endmodule

//--- source/wb_csr_access.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_csr_access import wb_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s4_valid,
    input  fu_e       s4_fu,
    input  uop_t      s4_uop,
    input  word_t     s4_opr_a,
    input  word_t     s4_opr_b,
    input  logic      pipe_progress,
    input  word_t     csr_rdata,
    output logic      csr_en,
    output logic      csr_wr,
    output logic      csr_wr_set,
    output logic      csr_wr_clr,
    output csr_addr_t csr_addr,
    output word_t     csr_wdata,
    output logic      csr_gpr_wen,
    output word_t     csr_gpr_wdata
);

    logic fu_csr;
    logic csr_done;                           // Access already issued

    assign fu_csr = s4_valid && (s4_fu == FU_CSR);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !pipe_progress && (csr_done || csr_en);
        end
    end

    // One access per instruction
    assign csr_en     = fu_csr && !csr_done;
    assign csr_wr     = csr_en && s4_uop[`WB_CSR_WR];
    assign csr_wr_set = csr_en && s4_uop[`WB_CSR_SET];
    assign csr_wr_clr = csr_en && s4_uop[`WB_CSR_CLR];
    assign csr_addr   = s4_opr_b[`WB_CSR_AW-1:0];   // Address from operand B
    assign csr_wdata  = s4_opr_a;

    // Read data only valid in the access cycle
    assign csr_gpr_wen   = csr_en && s4_uop[`WB_CSR_RD];
    assign csr_gpr_wdata = csr_rdata;

    // A stalled CSR op must not access twice
    a_csr_once : assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_en && !pipe_progress |=> !csr_en)
        else $error("Repeated CSR access for one instruction");

endmodule

//--- cfu/wb_ctrl_flow.sv
`timescale 1ns/10ps

module wb_ctrl_flow import wb_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        s4_valid,
    input  fu_e         s4_fu,
    input  uop_t        s4_uop,
    input  reg_idx_t    s4_rd,
    input  word_t       s4_opr_a,
    input  logic        s4_trap,
    input  word_t       next_pc,
    input  logic        pipe_progress,
    input  logic        lsu_trap,
    input  logic        lsu_is_store,
    input  logic        csr_error,
    input  word_t       csr_mepc,
    input  word_t       csr_mtvec,
    input  logic        cf_ack,
    output logic        cf_req,
    output word_t       cf_target,
    output logic        cfu_busy,
    output logic        exec_mret,
    output logic        trap_cpu,
    output trap_cause_e trap_cause,
    output logic        link_wen,
    output word_t       link_wdata
);

    cfu_op_e cfu_op;
    logic    fu_cfu;
    logic    cfu_taken;                       // Branch or jump redirect
    logic    cfu_ebreak;
    logic    cfu_ecall;
    logic    cfu_mret;
    logic    csr_trap;
    logic    tgt_trap;                        // Target is the trap vector
    logic    cf_want;
    logic    cfu_done;                        // Redirect acked, still stalled

    // Decode
    // --------------------
    assign cfu_op     = cfu_op_e'(s4_uop);
    assign fu_cfu     = s4_valid && (s4_fu == FU_CFU);
    assign cfu_taken  = fu_cfu && (cfu_op == CFU_TAKEN || cfu_op == CFU_JALI ||
                                   cfu_op == CFU_JALR);
    assign cfu_ebreak = fu_cfu && (cfu_op == CFU_EBREAK);
    assign cfu_ecall  = fu_cfu && (cfu_op == CFU_ECALL);
    assign cfu_mret   = fu_cfu && (cfu_op == CFU_MRET);
    assign csr_trap   = s4_valid && (s4_fu == FU_CSR) && csr_error;

    assign tgt_trap = cfu_ebreak || cfu_ecall || csr_trap || lsu_trap ||
                      (s4_valid && s4_trap);
    assign trap_cpu = tgt_trap;

    // Request and handshake
    // --------------------
    assign cf_want  = cfu_taken || cfu_mret || tgt_trap;  // Not-taken never asks
    assign cf_req   = cf_want && !cfu_done;
    assign cfu_busy = cf_req && !cf_ack;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || (cf_req && cf_ack));
        end
    end

    always_comb begin
        if (tgt_trap) begin
            cf_target = csr_mtvec;
        end else if (cfu_mret) begin
            cf_target = csr_mepc;                 // Return from handler
        end else begin
            cf_target = s4_opr_a;                 // Jump or branch target
        end
    end

    assign exec_mret = cfu_mret && pipe_progress;  // Single pulse at retire

    // Cause priority, highest first
    always_comb begin
        if (lsu_trap && !lsu_is_store) begin
            trap_cause = TRAP_LDACCESS;
        end else if (lsu_trap && lsu_is_store) begin
            trap_cause = TRAP_STACCESS;
        end else if (cfu_ebreak) begin
            trap_cause = TRAP_BREAKPT;
        end else if (cfu_ecall) begin
            trap_cause = TRAP_ECALLM;
        end else if (csr_trap) begin
            trap_cause = TRAP_IOPCODE;
        end else begin
            trap_cause = trap_cause_e'({1'b0, s4_rd});  // Upstream cause code
        end
    end

    // Link = address of the following instruction
    assign link_wen   = fu_cfu && (cfu_op == CFU_JALI || cfu_op == CFU_JALR);
    assign link_wdata = next_pc;

    // Target must not move under an open request
    a_tgt_stable : assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target))
        else $error("Control-flow target changed before acknowledge");

endmodule

//--- lsu/wb_load_unit.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_load_unit import wb_pkg::*; (
    input  logic  g_clk,
    input  logic  g_resetn,
    input  logic  s4_valid,
    input  fu_e   s4_fu,
    input  uop_t  s4_uop,
    input  word_t s4_opr_a,
    input  word_t s4_opr_b,
    input  logic  pipe_progress,
    input  logic  dmem_recv,
    input  logic  dmem_error,
    input  word_t dmem_rdata,
    output logic  dmem_ack,
    output logic  lsu_busy,
    output logic  lsu_trap,
    output logic  lsu_is_store,
    output logic  lsu_gpr_wen,
    output word_t lsu_gpr_wdata
);

    logic      fu_lsu;
    logic      lsu_load;
    logic      lsu_signed;
    lsu_size_e lsu_size;
    logic      rsp_seen;                      // Response already taken
    logic      rsp_take;                      // Response accepted now
    logic      err_seen;                      // Bus error held to retire
    logic [3:0] lsu_strb;
    word_t     masked;
    word_t     shifted;

    assign fu_lsu       = s4_valid && (s4_fu == FU_LSU);
    assign lsu_load     = fu_lsu && s4_uop[`WB_LSU_LOAD];
    assign lsu_is_store = fu_lsu && s4_uop[`WB_LSU_STORE];
    assign lsu_signed   = s4_uop[`WB_LSU_SIGNED];
    assign lsu_size     = lsu_size_e'(s4_uop[`WB_LSU_SZ_LO +: 2]);
    assign lsu_strb     = s4_opr_a[3:0];      // Strobes from memory stage

    // Response tracking
    // --------------------
    assign dmem_ack = fu_lsu && !rsp_seen;
    assign rsp_take = dmem_ack && dmem_recv;
    assign lsu_busy = fu_lsu && !(rsp_seen || rsp_take);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
        end else begin
            rsp_seen <= !pipe_progress && (rsp_seen || rsp_take);
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn || pipe_progress) begin
            err_seen <= 1'b0;                     // Cleared at retire
        end else begin
            err_seen <= err_seen || (rsp_take && dmem_error);
        end
    end

    assign lsu_trap    = err_seen || (rsp_take && dmem_error);
    assign lsu_gpr_wen = lsu_load && rsp_take && !dmem_error;  // No write on error

    // Data alignment
    // --------------------
    // Drop bytes outside the access, then bring the addressed byte to bit 0
    assign masked  = dmem_rdata & {{8{lsu_strb[3]}}, {8{lsu_strb[2]}},
                                   {8{lsu_strb[1]}}, {8{lsu_strb[0]}}};
    assign shifted = masked >> {s4_opr_b[1:0], 3'b000};

    always_comb begin
        case (lsu_size)
            LSU_BYTE: begin
                lsu_gpr_wdata = {{24{lsu_signed && shifted[7]}}, shifted[7:0]};
            end
            LSU_HALF: begin
                lsu_gpr_wdata = {{16{lsu_signed && shifted[15]}}, shifted[15:0]};
            end
            default: begin
                lsu_gpr_wdata = shifted;          // Full word
            end
        endcase
    end

    // Memory responses only accepted for an LSU instruction in the stage
    a_ack_lsu : assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_ack |-> s4_valid && (s4_fu == FU_LSU))
        else $error("dmem_ack raised outside an LSU instruction");

endmodule

//--- source/wb_stage_top.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module wb_stage_top import wb_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    // Instruction input
    input  logic        s4_valid,
    input  fu_e         s4_fu,
    input  uop_t        s4_uop,
    input  reg_idx_t    s4_rd,
    input  word_t       s4_opr_a,
    input  word_t       s4_opr_b,
    input  isize_t      s4_size,
    input  logic        s4_trap,
    output logic        s4_busy,
    // Control flow
    output logic        cf_req,
    output word_t       cf_target,
    input  logic        cf_ack,
    // Data memory response
    input  logic        dmem_recv,
    input  word_t       dmem_rdata,
    input  logic        dmem_error,
    output logic        dmem_ack,
    // CSR file
    output logic        csr_en,
    output logic        csr_wr,
    output logic        csr_wr_set,
    output logic        csr_wr_clr,
    output csr_addr_t   csr_addr,
    output word_t       csr_wdata,
    input  word_t       csr_rdata,
    input  logic        csr_error,
    input  word_t       csr_mepc,
    input  word_t       csr_mtvec,
    // GPR write and traps
    output logic        gpr_wen,
    output reg_idx_t    gpr_rd,
    output word_t       gpr_wdata,
    output logic        trap_cpu,
    output trap_cause_e trap_cause,
    output word_t       trap_pc,
    output logic        exec_mret,
    output logic        hold_lsu_req
);

    logic  pipe_progress;
    word_t s4_pc;
    word_t next_pc;
    logic  cfu_busy, lsu_busy, lsu_trap, lsu_is_store;
    logic  alu_gpr_wen, csr_gpr_wen, link_wen, lsu_gpr_wen;
    word_t csr_gpr_wdata, link_wdata, lsu_gpr_wdata;

    wb_pc_tracker u_pc (
        .g_clk, .g_resetn, .s4_valid, .s4_busy, .s4_size,
        .cf_req, .cf_ack, .cf_target,
        .pipe_progress, .s4_pc, .next_pc
    );

    wb_csr_access u_csr (
        .g_clk, .g_resetn, .s4_valid, .s4_fu, .s4_uop, .s4_opr_a, .s4_opr_b,
        .pipe_progress, .csr_rdata, .csr_en, .csr_wr, .csr_wr_set, .csr_wr_clr,
        .csr_addr, .csr_wdata, .csr_gpr_wen, .csr_gpr_wdata
    );

    wb_ctrl_flow u_cfu (
        .g_clk, .g_resetn, .s4_valid, .s4_fu, .s4_uop, .s4_rd, .s4_opr_a,
        .s4_trap, .next_pc, .pipe_progress, .lsu_trap, .lsu_is_store,
        .csr_error, .csr_mepc, .csr_mtvec, .cf_ack, .cf_req, .cf_target,
        .cfu_busy, .exec_mret, .trap_cpu, .trap_cause, .link_wen, .link_wdata
    );

    wb_load_unit u_lsu (
        .g_clk, .g_resetn, .s4_valid, .s4_fu, .s4_uop, .s4_opr_a, .s4_opr_b,
        .pipe_progress, .dmem_recv, .dmem_error, .dmem_rdata, .dmem_ack,
        .lsu_busy, .lsu_trap, .lsu_is_store, .lsu_gpr_wen, .lsu_gpr_wdata
    );

    // Stall and hold
    // --------------------
    assign s4_busy      = cfu_busy || lsu_busy;
    assign hold_lsu_req = cf_req || lsu_busy;     // No new memory ops yet

    // GPR writeback
    // --------------------
    assign alu_gpr_wen = s4_valid && (s4_fu == FU_ALU);  // Result in operand A

    // Trapping instructions never write
    assign gpr_wen = !s4_trap && !trap_cpu &&
                     (alu_gpr_wen || csr_gpr_wen || link_wen || lsu_gpr_wen);

    assign gpr_wdata = {`WB_XLEN{alu_gpr_wen}} & s4_opr_a      |
                       {`WB_XLEN{csr_gpr_wen}} & csr_gpr_wdata |
                       {`WB_XLEN{link_wen}}    & link_wdata    |
                       {`WB_XLEN{lsu_gpr_wen}} & lsu_gpr_wdata;

    assign gpr_rd  = s4_rd;
    assign trap_pc = s4_pc;                       // PC of instruction in stage

endmodule

//--- tb/tb_wb_ref.svh
`ifndef TB_WB_REF_SVH
`define TB_WB_REF_SVH

// Pick the addressed bytes and extend them
function automatic word_t load_ref(word_t data, logic [1:0] off, logic [1:0] size, logic sgn);
    word_t sh;
    case (off)
        2'd0: sh = data;
        2'd1: sh = {8'd0, data[31:8]};
        2'd2: sh = {16'd0, data[31:16]};
        default: sh = {24'd0, data[31:24]};
    endcase
    case (size)
        2'd0: return sgn ? {{24{sh[7]}}, sh[7:0]} : {24'd0, sh[7:0]};
        2'd1: return sgn ? {{16{sh[15]}}, sh[15:0]} : {16'd0, sh[15:0]};
        default: return sh;
    endcase
endfunction

// Address of the following instruction, also the JAL/JALR link value
function automatic word_t link_ref(word_t pc, logic [1:0] size);
    case (size)
        2'd0: return pc;                      // No instruction
        2'd1: return pc + 32'd2;              // 16-bit instruction
        2'd2: return pc + 32'd4;              // 32-bit instruction
        default: return pc + 32'd6;
    endcase
endfunction

// Trap cause by priority with the highest first
function automatic logic [5:0] cause_ref(logic ld_err, logic st_err, logic ebreak,
                                         logic ecall, logic csr_err, logic [4:0] rd);
    if (ld_err)  return 6'd5;
    if (st_err)  return 6'd7;
    if (ebreak)  return 6'd3;
    if (ecall)   return 6'd11;
    if (csr_err) return 6'd2;
    return {1'b0, rd};                        // Upstream cause
endfunction

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

//--- tb/tb_wb_stage.sv
`timescale 1ns/10ps
`include "wb_cfg.svh"

module tb_wb_stage import wb_pkg::*; ();

    localparam int N_INSTR = 81;              // Sum of all test lengths

    logic g_clk, g_resetn;
    logic s4_valid, s4_trap, s4_busy;
    fu_e s4_fu;
    uop_t s4_uop;
    reg_idx_t s4_rd;
    word_t s4_opr_a, s4_opr_b;
    isize_t s4_size;
    logic cf_req, cf_ack, dmem_recv, dmem_error, dmem_ack;
    word_t cf_target, dmem_rdata;
    logic csr_en, csr_wr, csr_wr_set, csr_wr_clr, csr_error;
    csr_addr_t csr_addr;
    word_t csr_wdata, csr_rdata, csr_mepc, csr_mtvec;
    logic gpr_wen, trap_cpu, exec_mret, hold_lsu_req;
    reg_idx_t gpr_rd;
    word_t gpr_wdata, trap_pc;
    trap_cause_e trap_cause;

    // Expectations for the instruction in the stage
    logic exp_wen, exp_req, exp_trap, exp_mret, exp_csr;
    word_t exp_wdata, exp_target, exp_pc, pc_model;
    logic [5:0] exp_cause;
    csr_addr_t exp_caddr;
    logic [2:0] exp_cwr;                      // Clear, set, write
    word_t exp_cwdata;
    // Environment settings per instruction
    int mem_wait, cf_wait;
    word_t mem_data, csr_val;
    logic mem_err, csr_err;
    // Observed during the instruction
    logic wr_seen, req_seen;
    int csr_cnt, mret_cnt;
    logic mem_pend;                           // LSU response still expected
    logic lsu_wait, exp_cf;
    int n_checks, n_errors;
    string cur_test;
    logic [15:0] lfsr;

    `include "tb_wb_ref.svh"

    wb_stage_top u_dut (.*);

    always #2 g_clk = ~g_clk;                 // 4 ns period

    function automatic logic [31:0] take(int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);           // One step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(string field, logic [31:0] expected, logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, field,
                     expected, actual);
        end
    endtask

    task automatic clear_exp;
        exp_wen = 0;
        exp_req = 0;
        exp_trap = 0;
        exp_mret = 0;
        exp_csr = 0;
        exp_wdata = '0;
        exp_target = '0;
        exp_cause = '0;
        exp_caddr = '0;
        exp_cwr = '0;
        exp_cwdata = '0;
        mem_err = 0;
        csr_err = 0;
        csr_val = '0;
    endtask

    // Present one instruction and wait for it to retire
    task automatic issue(fu_e fu, logic [4:0] uop, logic [4:0] rd, word_t a, word_t b,
                         logic [1:0] size, logic trap);
        logic [31:0] r;
        r = take(2);
        mem_wait = int'(r);
        r = take(2);
        cf_wait = int'(r % 3);
        @(posedge g_clk);
        exp_pc = pc_model;
        mem_pend = (fu == FU_LSU);
        s4_valid <= 1'b1;
        s4_fu <= fu;
        s4_uop <= uop;
        s4_rd <= rd;
        s4_opr_a <= a;
        s4_opr_b <= b;
        s4_size <= size;
        s4_trap <= trap;
        csr_rdata <= csr_val;
        csr_error <= csr_err;
        do begin
            @(negedge g_clk);
        end while (s4_busy);
        pc_model = exp_req ? exp_target : link_ref(exp_pc, size);
        @(posedge g_clk);
        s4_valid <= 1'b0;                     // One idle cycle between instructions
        s4_trap <= 1'b0;
        csr_error <= 1'b0;
    endtask

    task automatic end_test(int base_chk, int base_err);
        $display("%s done: %0d checks, %0d errors", cur_test, n_checks - base_chk,
                 n_errors - base_err);
    endtask

    // Compare process
    // --------------------
    always @(negedge g_clk) begin
        if (g_resetn && s4_valid) begin
            lsu_wait = mem_pend && !dmem_recv;     // Response not here yet
            exp_cf = exp_req && !lsu_wait;         // LSU traps only after the response
            check("s4_busy", 32'(lsu_wait || (exp_cf && !cf_ack)), 32'(s4_busy));
            check("cf_req level", 32'(exp_cf), 32'(cf_req));
            check("dmem_ack", 32'(mem_pend), 32'(dmem_ack));
            check("hold_lsu_req", 32'(exp_cf || lsu_wait), 32'(hold_lsu_req));
            mem_pend = lsu_wait;
            if (gpr_wen) begin
                wr_seen = 1;
                check("gpr_wdata", exp_wdata, gpr_wdata);
                check("gpr_rd", 32'(s4_rd), 32'(gpr_rd));
            end
            if (cf_req) begin
                req_seen = 1;
                check("cf_target", exp_target, cf_target);
            end
            if (csr_en) begin
                csr_cnt++;
                check("csr_addr", 32'(exp_caddr), 32'(csr_addr));
                check("csr_wdata", exp_cwdata, csr_wdata);
                check("csr_wr_flags", 32'(exp_cwr), 32'({csr_wr_clr, csr_wr_set, csr_wr}));
            end else begin
                check("csr_wr_flags", 0, 32'({csr_wr_clr, csr_wr_set, csr_wr}));
            end
            if (exec_mret) mret_cnt++;
            if (!s4_busy) begin               // Retire cycle
                check("gpr_wen", 32'(exp_wen), 32'(wr_seen));
                check("cf_req", 32'(exp_req), 32'(req_seen));
                check("trap_cpu", 32'(exp_trap), 32'(trap_cpu));
                check("exec_mret", 32'(exp_mret), 32'(mret_cnt));
                check("csr_en", 32'(exp_csr), 32'(csr_cnt));
                check("trap_pc", exp_pc, trap_pc);
                if (exp_trap) check("trap_cause", 32'(exp_cause), 32'(trap_cause));
                wr_seen = 0;
                req_seen = 0;
                csr_cnt = 0;
                mret_cnt = 0;
            end
        end
    end

    // Memory responder
    always begin
        @(negedge g_clk);
        if (dmem_recv && dmem_ack) begin
            @(posedge g_clk);
            dmem_recv <= 1'b0;
        end else if (dmem_ack && !dmem_recv) begin
            if (mem_wait == 0) begin
                @(posedge g_clk);
                dmem_recv <= 1'b1;
                dmem_rdata <= mem_data;
                dmem_error <= mem_err;
            end else begin
                mem_wait--;
            end
        end
    end

    // Control-flow acknowledge
    always begin
        @(negedge g_clk);
        if (cf_req && cf_ack) begin
            @(posedge g_clk);
            cf_ack <= 1'b0;
        end else if (cf_req && !cf_ack) begin
            if (cf_wait == 0) begin
                @(posedge g_clk);
                cf_ack <= 1'b1;
            end else begin
                cf_wait--;
            end
        end
    end

    // Watchdog
    initial begin
        #(N_INSTR * 10 * 4 + 100);
        $display("Timeout: instructions did not retire in time");
        $display("Verification failed");
        $finish;
    end

    // Tests
    // --------------------
    task automatic test_reset;
        int bc, be;
        bc = n_checks;
        be = n_errors;
        cur_test = "reset";
        @(negedge g_clk);
        check("s4_busy", 0, 32'(s4_busy));
        check("cf_req", 0, 32'(cf_req));
        check("csr_en", 0, 32'(csr_en));
        check("gpr_wen", 0, 32'(gpr_wen));
        check("dmem_ack", 0, 32'(dmem_ack));
        check("trap_cpu", 0, 32'(trap_cpu));
        check("exec_mret", 0, 32'(exec_mret));
        check("trap_pc", `WB_PC_RESET, trap_pc);
        end_test(bc, be);
    endtask

    task automatic test_alu;
        logic [31:0] r, a;
        int bc, be;
        bc = n_checks;
        be = n_errors;
        cur_test = "alu";
        for (int i = 0; i < 10; i++) begin
            a = take(32);
            r = take(6);
            clear_exp();
            exp_wen = 1;
            exp_wdata = a;
            issue(FU_ALU, 5'd0, r[4:0], a, '0, r[5] ? 2'd2 : 2'd1, 1'b0);
        end
        end_test(bc, be);
    endtask

    // Loads and stores with or without bus errors
    task automatic test_lsu(string name, int count, logic err);
        logic [31:0] r, addr, data;
        logic [1:0] sz, off;
        logic [3:0] strb;
        logic sgn, st;
        int bc, be;
        bc = n_checks;
        be = n_errors;
        cur_test = name;
        for (int i = 0; i < count; i++) begin
            data = take(32);
            r = take(8);
            sz = 2'(r[1:0] % 3);
            off = (sz == 2'd0) ? r[3:2] : (sz == 2'd1) ? {r[2], 1'b0} : 2'd0;
            sgn = r[4];
            st = err ? r[5] : (r[7:5] == 3'd0);
            strb = (sz == 2'd0) ? 4'b0001 << off : (sz == 2'd1) ? 4'b0011 << off : 4'hf;
            r = take(32);
            addr = {r[31:2], off};
            clear_exp();
            mem_data = data;
            mem_err = err;
            exp_wen = !st && !err;
            exp_wdata = load_ref(data, off, sz, sgn);
            if (err) begin
                exp_req = 1;
                exp_trap = 1;
                exp_target = csr_mtvec;
                exp_cause = cause_ref(!st, st, 0, 0, 0, r[4:0]);
            end
            issue(FU_LSU, {st, sgn, sz, !st}, r[4:0], {28'd0, strb}, addr, 2'd2, 1'b0);
        end
        end_test(bc, be);
    endtask

    task automatic test_jump;
        logic [31:0] r, tgt;
        logic [4:0] op;
        int bc, be;
        bc = n_checks;
        be = n_errors;
        cur_test = "jump";
        for (int i = 0; i < 12; i++) begin
            r = take(30);
            tgt = {r[29:0], 2'b00};
            r = take(5);
            clear_exp();
            case (i % 5)
                0: op = CFU_JALI;
                1: op = CFU_JALR;
                2: op = CFU_TAKEN;
                3: op = CFU_NOP;
                default: op = CFU_MRET;
            endcase
            exp_req = (op != CFU_NOP);
            exp_target = (op == CFU_MRET) ? csr_mepc : tgt;
            exp_mret = (op == CFU_MRET);
            exp_wen = (op == CFU_JALI || op == CFU_JALR);
            exp_wdata = link_ref(pc_model, 2'd2);
            issue(FU_CFU, op, r[4:0], tgt, '0, 2'd2, 1'b0);
        end
        end_test(bc, be);
    endtask

    task automatic test_csr;
        logic [31:0] r, a, b;
        int bc, be;
        bc = n_checks;
        be = n_errors;
        cur_test = "csr";
        for (int i = 0; i < 12; i++) begin
            a = take(32);
            b = take(32);
            r = take(9);
            clear_exp();
            csr_val = take(32);
            csr_err = (i % 4 == 3);
            exp_csr = 1;
            exp_caddr = b[11:0];
            exp_cwr = r[3:1];
            exp_cwdata = a;
            exp_wen = r[0] && !csr_err;
            exp_wdata = csr_val;
            if (csr_err) begin
                exp_req = 1;
                exp_trap = 1;
                exp_target = csr_mtvec;
                exp_cause = cause_ref(0, 0, 0, 0, 1, r[8:4]);
            end
            issue(FU_CSR, {1'b0, r[3:0]}, r[8:4], a, b, 2'd2, 1'b0);
        end
        end_test(bc, be);
    endtask

    task automatic test_trap;
        logic [31:0] r, a;
        int bc, be;
        bc = n_checks;
        be = n_errors;
        cur_test = "trap";
        for (int i = 0; i < 9; i++) begin
            a = take(32);
            r = take(5);
            clear_exp();
            exp_req = 1;
            exp_trap = 1;
            exp_target = csr_mtvec;
            exp_cause = cause_ref(0, 0, i % 3 == 1, i % 3 == 0, 0, r[4:0]);
            if (i % 3 == 0) issue(FU_CFU, CFU_ECALL, r[4:0], a, '0, 2'd2, 1'b0);
            else if (i % 3 == 1) issue(FU_CFU, CFU_EBREAK, r[4:0], a, '0, 2'd2, 1'b0);
            else issue(FU_ALU, 5'd0, r[4:0], a, '0, 2'd2, 1'b1);  // Upstream fault
        end
        end_test(bc, be);
    endtask

    initial begin
        g_clk = 0;
        g_resetn = 0;
        s4_valid = 0;
        s4_fu = FU_ALU;
        s4_uop = '0;
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_size = '0;
        s4_trap = 0;
        cf_ack = 0;
        dmem_recv = 0;
        dmem_rdata = '0;
        dmem_error = 0;
        csr_rdata = '0;
        csr_error = 0;
        csr_mepc = 32'h8000_2000;
        csr_mtvec = 32'h8000_0100;
        lfsr = 16'd25;
        pc_model = `WB_PC_RESET;
        wr_seen = 0;
        req_seen = 0;
        csr_cnt = 0;
        mret_cnt = 0;
        mem_pend = 0;
        lsu_wait = 0;
        exp_cf = 0;
        n_checks = 0;
        n_errors = 0;
        mem_wait = 0;
        cf_wait = 0;
        mem_data = '0;
        clear_exp();
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        test_reset();
        test_alu();
        test_lsu("load", 30, 1'b0);
        test_lsu("bus_error", 8, 1'b1);
        test_jump();
        test_csr();
        test_trap();
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- wb_stage.f
+incdir+common
+incdir+tb
common/wb_pkg.sv
source/wb_pc_tracker.sv
source/wb_csr_access.sv
cfu/wb_ctrl_flow.sv
lsu/wb_load_unit.sv
source/wb_stage_top.sv
tb/tb_wb_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_wb_stage -f wb_stage.f -o sim_wb_stage &&
./obj_dir/sim_wb_stage | tee /dev/stderr | grep -q "Verification passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
